// ==== verilog/fq_pkg.sv ====
/*
 * Shared types for the packet queue transmit path.
 * Byte and dibit widths are fixed here for every module.
 * Packet length, slot count and idle timeout are module parameters
 * and are set at the top level.
 */
package fq_pkg;

	// Bits per data byte
	localparam int BYTE_LEN = 8;

	// RMII transmits two bits per clock
	localparam int DIBIT_LEN = 2;

	localparam int DIBITS_PER_BYTE = BYTE_LEN / DIBIT_LEN;

	typedef logic [BYTE_LEN-1:0] byte_t;

	typedef logic [DIBIT_LEN-1:0] dibit_t;

	// Transmit sequencer states
	typedef enum logic [1:0] {
		TX_IDLE   = 2'd0,
		TX_START  = 2'd1,
		TX_ACTIVE = 2'd2
	} tx_state_e;

endpackage

// ==== verilog/packet_writer.sv ====
/*
 * Writes incoming bytes into the tail slot of the packet buffer.
 * The write path is combinational, so the RAM commits each byte on
 * the edge of its strobe. A packet that completes on a full queue
 * overwrites the same slot next time. A partial packet is thrown
 * away after IDLE_CYCLES quiet cycles. IDLE_CYCLES must be at least 2.
 */
`timescale 1ns/1ps

module packet_writer import fq_pkg::*; #(
	parameter int PKT_LEN     = 16,
	parameter int SLOT_COUNT  = 8,
	parameter int IDLE_CYCLES = 64
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 in_valid,
	input  byte_t                                in_byte,
	input  logic [$clog2(SLOT_COUNT)-1:0]           head,
	output logic [$clog2(SLOT_COUNT)-1:0]           tail,
	output logic                                 wr_en,
	output logic [$clog2(PKT_LEN*SLOT_COUNT)-1:0] wr_addr,
	output byte_t                                wr_data
);

	localparam int SLOT_W = $clog2(SLOT_COUNT);
	localparam int OFF_W  = $clog2(PKT_LEN);
	localparam int IDLE_W = $clog2(IDLE_CYCLES);

	logic [OFF_W-1:0]  byte_cnt;
	logic [IDLE_W-1:0] idle_cnt;
	logic [SLOT_W-1:0] tail_next;
	logic              queue_full;
	logic              idle_expired;

	assign tail_next    = tail + 1'b1;
	assign queue_full   = (tail_next == head);
	assign idle_expired = (byte_cnt != '0) && (idle_cnt == IDLE_W'(IDLE_CYCLES - 1));

	// Byte offset within the slot forms the low address bits
	assign wr_en   = in_valid;
	assign wr_addr = {tail, byte_cnt};
	assign wr_data = in_byte;

	always_ff @(posedge clk) begin
		if (rst) begin
			byte_cnt <= '0;
			idle_cnt <= '0;
			tail     <= '0;
		end else if (in_valid) begin
			idle_cnt <= '0;
			if (byte_cnt == OFF_W'(PKT_LEN - 1)) begin
				byte_cnt <= '0;
				// On overflow the slot is reused and this packet is lost
				if (!queue_full)
					tail <= tail_next;
			end else begin
				byte_cnt <= byte_cnt + 1'b1;
			end
		end else if (idle_expired) begin
			// Stream went quiet mid packet
			byte_cnt <= '0;
			idle_cnt <= '0;
		end else if (byte_cnt != '0) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

endmodule

// ==== verilog/packet_buffer_ram.sv ====
/*
 * Simple dual-port byte RAM of PKT_LEN x SLOT_COUNT entries.
 * Read data is registered and arrives one cycle after rd_en,
 * together with rd_valid. Contents are not cleared by reset.
 */
`timescale 1ns/1ps

module packet_buffer_ram import fq_pkg::*; #(
	parameter int PKT_LEN    = 16,
	parameter int SLOT_COUNT = 8
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 wr_en,
	input  logic [$clog2(PKT_LEN*SLOT_COUNT)-1:0] wr_addr,
	input  byte_t                                wr_data,
	input  logic                                 rd_en,
	input  logic [$clog2(PKT_LEN*SLOT_COUNT)-1:0] rd_addr,
	output logic                                 rd_valid,
	output byte_t                                rd_data
);

	byte_t mem [PKT_LEN * SLOT_COUNT];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

	// Drops any read still in flight
	always_ff @(posedge clk) begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

endmodule

// ==== verilog/tx_sequencer.sv ====
/*
 * Owns the queue head and starts one slot transmission at a time.
 * tx_start is high for one cycle, in TX_START, and start_slot
 * follows head. The head advances only on pkt_done.
 */
`timescale 1ns/1ps

module tx_sequencer import fq_pkg::*; #(
	parameter int SLOT_COUNT = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [$clog2(SLOT_COUNT)-1:0] tail,
	input  logic                        pkt_done,
	output logic [$clog2(SLOT_COUNT)-1:0] head,
	output logic                        tx_start,
	output logic [$clog2(SLOT_COUNT)-1:0] start_slot
);

	tx_state_e state;

	assign tx_start   = (state == TX_START);
	assign start_slot = head;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			head  <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					// Queue holds a packet
					if (head != tail)
						state <= TX_START;
				end
				TX_START: state <= TX_ACTIVE;
				TX_ACTIVE: begin
					if (pkt_done) begin
						head  <= head + 1'b1;
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/slot_streamer.sv ====
/*
 * Streams the bytes of one slot from the packet buffer.
 * tx_start acts as the first byte request. Each later byte_req reads
 * one more byte, and byte_valid follows its request by two cycles.
 * pkt_done pulses once the serializer has taken the final byte,
 * which is signalled by the first byte_req after it was handed over.
 */
`timescale 1ns/1ps

module slot_streamer import fq_pkg::*; #(
	parameter int PKT_LEN    = 16,
	parameter int SLOT_COUNT = 8
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 tx_start,
	input  logic [$clog2(SLOT_COUNT)-1:0]           start_slot,
	input  logic                                 byte_req,
	output logic                                 rd_en,
	output logic [$clog2(PKT_LEN*SLOT_COUNT)-1:0] rd_addr,
	input  logic                                 rd_valid,
	input  byte_t                                rd_data,
	output logic                                 byte_valid,
	output byte_t                                byte_data,
	output logic                                 last_byte,
	output logic                                 pkt_done
);

	localparam int OFF_W = $clog2(PKT_LEN);
	localparam int CNT_W = $clog2(PKT_LEN + 1);

	// Reads issued for the current slot
	logic [CNT_W-1:0] issue_cnt;
	// Bytes handed to the serializer
	logic [OFF_W-1:0] out_cnt;
	logic             last_sent;

	assign byte_valid = rd_valid;
	assign byte_data  = rd_data;
	assign last_byte  = rd_valid && (out_cnt == OFF_W'(PKT_LEN - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_en     <= 1'b0;
			pkt_done  <= 1'b0;
			issue_cnt <= CNT_W'(PKT_LEN);
			out_cnt   <= '0;
			last_sent <= 1'b0;
		end else begin
			rd_en    <= 1'b0;
			pkt_done <= 1'b0;
			if (tx_start) begin
				rd_en     <= 1'b1;
				rd_addr   <= {start_slot, {OFF_W{1'b0}}};
				issue_cnt <= CNT_W'(1);
				out_cnt   <= '0;
				last_sent <= 1'b0;
			end else begin
				if (byte_req && issue_cnt != CNT_W'(PKT_LEN)) begin
					rd_en     <= 1'b1;
					rd_addr   <= rd_addr + 1'b1;
					issue_cnt <= issue_cnt + 1'b1;
				end
				if (rd_valid)
					out_cnt <= out_cnt + 1'b1;
				if (last_byte) begin
					last_sent <= 1'b1;
				end else if (byte_req && last_sent) begin
					pkt_done  <= 1'b1;
					last_sent <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== verilog/dibit_serializer.sv ====
/*
 * Sends bytes as dibits, least significant first, with eth_txen high.
 * byte_req pulses on the first dibit of every byte. A byte that
 * arrives mid byte waits in a one-entry holding register, so bytes
 * chain without a gap. eth_txen drops after a byte tagged last_byte.
 */
`timescale 1ns/1ps

module dibit_serializer import fq_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   byte_valid,
	input  byte_t  byte_data,
	input  logic   last_byte,
	output logic   byte_req,
	output logic   eth_txen,
	output dibit_t eth_txd
);

	localparam int DCNT_W = $clog2(DIBITS_PER_BYTE);

	logic [BYTE_LEN-DIBIT_LEN-1:0] shreg;
	logic [DCNT_W-1:0]            dcnt;
	logic                         cur_last;
	byte_t                        hold_data;
	logic                         hold_last;
	logic                         hold_valid;
	logic                         end_of_byte;
	logic                         load_go;
	logic                         load_direct;
	byte_t                        src_data;
	logic                         src_last;

	assign end_of_byte = (dcnt == DCNT_W'(DIBITS_PER_BYTE - 1));
	// Start a byte when idle, or chain on the last dibit of a non-final byte
	assign load_go     = (!eth_txen || (end_of_byte && !cur_last)) && (hold_valid || byte_valid);
	assign load_direct = load_go && !hold_valid;
	assign src_data    = hold_valid ? hold_data : byte_data;
	assign src_last    = hold_valid ? hold_last : last_byte;

	always_ff @(posedge clk) begin
		if (byte_valid) begin
			hold_data <= byte_data;
			hold_last <= last_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			byte_req   <= 1'b0;
			eth_txen   <= 1'b0;
			eth_txd    <= '0;
			dcnt       <= '0;
			cur_last   <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			byte_req   <= load_go;
			hold_valid <= (hold_valid && !load_go) || (byte_valid && !load_direct);
			if (load_go) begin
				eth_txen <= 1'b1;
				eth_txd  <= src_data[DIBIT_LEN-1:0];
				shreg    <= src_data[BYTE_LEN-1:DIBIT_LEN];
				dcnt     <= '0;
				cur_last <= src_last;
			end else if (eth_txen && !end_of_byte) begin
				eth_txd <= shreg[DIBIT_LEN-1:0];
				shreg   <= shreg >> DIBIT_LEN;
				dcnt    <= dcnt + 1'b1;
			end else if (eth_txen) begin
				// End of frame, or no byte ready
				eth_txen <= 1'b0;
				eth_txd  <= '0;
			end
		end
	end

endmodule

// ==== verilog/frame_queue_top.sv ====
/*
 * Packet queue with an RMII style transmitter.
 * Incoming bytes are plain strobes with no back-pressure.
 * PKT_LEN and SLOT_COUNT must be powers of two, and the queue
 * holds at most SLOT_COUNT - 1 packets. A packet that completes while
 * the queue is full is lost.
 */
`timescale 1ns/1ps

module frame_queue_top import fq_pkg::*; #(
	parameter int PKT_LEN     = 16,
	parameter int SLOT_COUNT  = 8,
	parameter int IDLE_CYCLES = 64
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   in_valid,
	input  byte_t  in_byte,
	output logic   eth_txen,
	output dibit_t eth_txd
);

	localparam int SLOT_W = $clog2(SLOT_COUNT);
	localparam int ADDR_W = $clog2(PKT_LEN * SLOT_COUNT);

	// Queue pointers
	logic [SLOT_W-1:0] head;
	logic [SLOT_W-1:0] tail;
	logic [SLOT_W-1:0] start_slot;

	// Packet buffer ports
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	byte_t             wr_data;
	logic              rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_valid;
	byte_t             rd_data;

	// Transmit control
	logic  tx_start;
	logic  pkt_done;
	logic  byte_req;
	logic  byte_valid;
	byte_t byte_data;
	logic  last_byte;

	packet_writer #(
		.PKT_LEN(PKT_LEN),
		.SLOT_COUNT(SLOT_COUNT),
		.IDLE_CYCLES(IDLE_CYCLES)
	) u_writer (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_byte(in_byte),
		.head(head),
		.tail(tail),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	packet_buffer_ram #(
		.PKT_LEN(PKT_LEN),
		.SLOT_COUNT(SLOT_COUNT)
	) u_ram (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	tx_sequencer #(
		.SLOT_COUNT(SLOT_COUNT)
	) u_seq (
		.clk(clk),
		.rst(rst),
		.tail(tail),
		.pkt_done(pkt_done),
		.head(head),
		.tx_start(tx_start),
		.start_slot(start_slot)
	);

	slot_streamer #(
		.PKT_LEN(PKT_LEN),
		.SLOT_COUNT(SLOT_COUNT)
	) u_streamer (
		.clk(clk),
		.rst(rst),
		.tx_start(tx_start),
		.start_slot(start_slot),
		.byte_req(byte_req),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.last_byte(last_byte),
		.pkt_done(pkt_done)
	);

	dibit_serializer u_serializer (
		.clk(clk),
		.rst(rst),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.last_byte(last_byte),
		.byte_req(byte_req),
		.eth_txen(eth_txen),
		.eth_txd(eth_txd)
	);

endmodule

// ==== bench/frame_queue_assert.sv ====
/*
 * Concurrent checks on the queue pointers and the sequencer state.
 * Bound into frame_queue_top. fired stays high once any check failed.
 */
`timescale 1ns/1ps

module frame_queue_assert import fq_pkg::*; #(
	parameter int SLOT_COUNT = 8
) (
	input logic                          clk,
	input logic                          rst,
	input tx_state_e                     state,
	input logic [$clog2(SLOT_COUNT)-1:0] head,
	input logic [$clog2(SLOT_COUNT)-1:0] tail,
	input logic                          tx_start,
	input logic                          eth_txen
);

	logic fired = 1'b0;

	// Head advances only on pkt_done in TX_ACTIVE
	head_moves_when_active: assert property (@(posedge clk) disable iff (rst)
		(state != TX_ACTIVE) |=> $stable(head))
		else begin
			fired = 1'b1;
			$error("head moved outside TX_ACTIVE");
		end

	// A tail advance never makes the queue look empty
	tail_never_meets_head: assert property (@(posedge clk) disable iff (rst)
		!$stable(tail) |-> (tail != head))
		else begin
			fired = 1'b1;
			$error("tail reached head on an advance");
		end

	// A start goes out only for a queued slot and eth_txen rises within four cycles
	start_launches_frame: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> (head != tail) ##[1:4] eth_txen)
		else begin
			fired = 1'b1;
			$error("tx_start without a queued slot or without eth_txen following");
		end

	txen_low_in_reset: assert property (@(posedge clk) rst |=> !eth_txen)
		else begin
			fired = 1'b1;
			$error("eth_txen high during reset");
		end

endmodule

bind frame_queue_top frame_queue_assert #(.SLOT_COUNT(SLOT_COUNT)) u_assert (
	.clk(clk),
	.rst(rst),
	.state(u_seq.state),
	.head(head),
	.tail(tail),
	.tx_start(tx_start),
	.eth_txen(eth_txen)
);

// ==== bench/frame_queue_tb.sv ====
/*
 * Testbench for the packet queue transmitter with default parameters.
 * Bytes come from an xorshift generator with a fixed seed. Received
 * packets are rebuilt from eth_txd and compared with the sent ones.
 * During the overflow burst, dropped packets may be skipped, but the
 * output must stay in order. The run stops at the first error.
 */
`timescale 1ns/1ps

module frame_queue_tb import fq_pkg::*;;

	localparam int PKT_LEN     = 16;
	localparam int SLOT_COUNT  = 8;
	localparam int IDLE_CYCLES = 64;
	localparam int SINGLE_PKTS = 6;
	localparam int BURST_PKTS  = 3 * SLOT_COUNT;
	localparam int MAX_GAP     = 8;
	localparam int NO_SKIP     = 32'h7fff_ffff;
	// Singles, the idle test packet, the burst and the final packet
	localparam int TOTAL_PKTS  = SINGLE_PKTS + 2 + BURST_PKTS;
	localparam int PKT_BUDGET  = 4 * PKT_LEN + 20 + PKT_LEN * MAX_GAP;
	localparam int WATCHDOG_CYCLES = TOTAL_PKTS * PKT_BUDGET + IDLE_CYCLES + PKT_LEN + 40;

	logic   clk;
	logic   rst;
	logic   in_valid;
	byte_t  in_byte;
	logic   eth_txen;
	dibit_t eth_txd;

	logic [31:0] rng_state = 32'h2bf0;

	// Model of every complete packet sent, PKT_LEN bytes each
	byte_t sent[$];
	int    sent_pkts = 0;
	int    next_pkt  = 0;
	int    skip_from = NO_SKIP;

	// Receive side
	byte_t rx_bytes[$];
	byte_t cur;
	int    dibits    = 0;
	int    rx_pkts   = 0;
	int    low_run   = 0;
	logic  prev_txen = 1'b0;

	frame_queue_top u_frame_queue_top (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_byte(in_byte),
		.eth_txen(eth_txen),
		.eth_txd(eth_txd)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic report_mismatch(string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_byte(byte_t got, byte_t exp, string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got 0x%02h expected 0x%02h", what, got, exp));
	endtask

	task automatic check_len(int got, int exp, string what);
		if (got != exp)
			report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	// Drives count bytes, each followed by a random gap below max_gap
	task automatic send_bytes(int count, int max_gap, bit keep);
		logic [31:0] r;
		int          gap;
		for (int i = 0; i < count; i++) begin
			r = xorshift32();
			@(negedge clk);
			in_valid = 1'b1;
			in_byte  = r[7:0];
			if (keep)
				sent.push_back(r[7:0]);
			gap = 0;
			if (max_gap > 0) begin
				r   = xorshift32();
				gap = int'(r % max_gap);
			end
			repeat (gap) begin
				@(negedge clk);
				in_valid = 1'b0;
			end
		end
		if (keep)
			sent_pkts++;
	endtask

	task automatic go_quiet(int cycles);
		repeat (cycles) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic wait_for_packets(int target);
		while (rx_pkts < target)
			@(posedge clk);
	endtask

	// Queue empty and transmitter idle
	task automatic wait_until_drained();
		do
			@(posedge clk);
		while (u_frame_queue_top.head != u_frame_queue_top.tail || eth_txen);
	endtask

	function automatic bit packet_matches(int idx);
		for (int k = 0; k < PKT_LEN; k++)
			if (rx_bytes[k] !== sent[idx * PKT_LEN + k])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic compare_packet();
		int idx;
		check_len(dibits, 4 * PKT_LEN, "eth_txen high cycles");
		idx = next_pkt;
		if (idx >= sent_pkts) begin
			$display("A packet came out of eth_txd with no packet left in the model");
			abort_run();
		end
		// Packets lost to overflow are skipped and order is kept
		if (next_pkt >= skip_from)
			while (idx < sent_pkts - 1 && !packet_matches(idx))
				idx++;
		for (int k = 0; k < PKT_LEN; k++)
			check_byte(rx_bytes[k], sent[idx * PKT_LEN + k],
				$sformatf("packet %0d byte %0d", idx, k));
		next_pkt = idx + 1;
		rx_pkts++;
	endtask

	// Rebuild bytes from dibits, least significant first
	always @(negedge clk) begin
		if (u_frame_queue_top.u_assert.fired) begin
			$display("A concurrent assertion on the DUT failed");
			abort_run();
		end
		if (eth_txen) begin
			if (!prev_txen && rx_pkts > 0 && low_run < 2)
				report_mismatch($sformatf("eth_txen low for only %0d cycles", low_run));
			cur[2 * (dibits % 4) +: 2] = eth_txd;
			dibits++;
			if (dibits % 4 == 0)
				rx_bytes.push_back(cur);
			low_run = 0;
		end else begin
			if (prev_txen) begin
				compare_packet();
				rx_bytes.delete();
				dibits = 0;
			end
			low_run++;
		end
		prev_txen = eth_txen;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run hung after %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		int          rx_before;
		logic [31:0] r;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_byte  = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// Single packets with random gaps
		for (int p = 0; p < SINGLE_PKTS; p++) begin
			send_bytes(PKT_LEN, MAX_GAP, 1'b1);
			go_quiet(1);
			wait_for_packets(sent_pkts);
		end

		// Partial packet dropped by the idle timeout
		r = xorshift32();
		send_bytes(1 + int'(r % (PKT_LEN - 1)), 0, 1'b0);
		go_quiet(IDLE_CYCLES + 8);
		send_bytes(PKT_LEN, MAX_GAP, 1'b1);
		go_quiet(1);
		wait_for_packets(sent_pkts);

		// Back to back burst that overflows the queue
		rx_before = rx_pkts;
		skip_from = sent_pkts + 1;
		repeat (BURST_PKTS) send_bytes(PKT_LEN, 0, 1'b1);
		go_quiet(1);
		wait_until_drained();
		if (rx_pkts - rx_before < SLOT_COUNT - 1)
			report_mismatch($sformatf("only %0d burst packets came out", rx_pkts - rx_before));
		skip_from = NO_SKIP;
		next_pkt  = sent_pkts;

		// One more packet through the emptied queue
		rx_before = rx_pkts;
		send_bytes(PKT_LEN, MAX_GAP, 1'b1);
		go_quiet(1);
		wait_for_packets(rx_before + 1);
		wait_until_drained();

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/fq_pkg.sv
verilog/packet_writer.sv
verilog/packet_buffer_ram.sv
verilog/tx_sequencer.sv
verilog/slot_streamer.sv
verilog/dibit_serializer.sv
verilog/frame_queue_top.sv
bench/frame_queue_assert.sv
bench/frame_queue_tb.sv
